// File: common/rename_defines.svh
// Rename stage sizes
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// physical register file
`define PHYS_REGS 32
`define PR_ADDR_W 5

// architectural registers, 0 and 1 are fixed
`define ARCH_REGS 12
`define RENAMED_REGS 10

// program counter halves
`define REG_PCH 4'd11
`define REG_PCL 4'd10

`endif

// File: common/rename_pkg.sv
// Rename stage types
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

    typedef logic [3:0] arch_reg_t;
    typedef logic [`PR_ADDR_W-1:0] phys_reg_t;

    // bit i stands for physical register i+2
    typedef logic [`PHYS_REGS-3:0] free_pool_t;

    // slot r holds the alias of architectural register r+2
    typedef logic [`RENAMED_REGS*`PR_ADDR_W-1:0] rat_t;
    typedef logic [`RENAMED_REGS-1:0] done_t;

    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_LOAD   = 4'b1100;
    localparam opcode_t OP_STORE  = 4'b1101;
    localparam opcode_t OP_TERM_A = 4'b1110;
    localparam opcode_t OP_TERM_B = 4'b1111;

endpackage

`default_nettype wire

// File: logic/dest_decode.sv
// Destination decoder
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module dest_decode (
    input  wire logic [23:0]         micro_op,
    output rename_pkg::arch_reg_t    dst_a,
    output rename_pkg::arch_reg_t    dst_b,
    output logic                     nop
);

    rename_pkg::opcode_t opcode;

    assign opcode = micro_op[23:20];

    always_comb begin
        case (opcode)
            rename_pkg::OP_LOAD: begin
                dst_a = 4'h0;
                dst_b = micro_op[15:12]; // loaded value only
            end
            rename_pkg::OP_STORE: begin
                dst_a = 4'h0;
                dst_b = 4'h0;
            end
            rename_pkg::OP_TERM_A, rename_pkg::OP_TERM_B: begin
                dst_a = `REG_PCH; // terminators write the pc
                dst_b = `REG_PCL;
            end
            default: begin
                dst_a = micro_op[19:16];
                dst_b = micro_op[15:12];
            end
        endcase
    end

    // opcode 0 with no destinations does nothing
    assign nop = (opcode == 4'h0) && (dst_a == 4'h0) && (dst_b == 4'h0);

endmodule

`default_nettype wire

// File: renamer/renamer_cell.sv
// Single destination rename
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module renamer_cell (
    input  wire rename_pkg::arch_reg_t  arch_reg,
    input  wire rename_pkg::free_pool_t free_pool,
    input  wire rename_pkg::rat_t       rat_aliases,
    input  wire rename_pkg::done_t      rat_done,
    output rename_pkg::free_pool_t      new_free_pool,
    output rename_pkg::rat_t            new_rat_aliases,
    output rename_pkg::done_t           new_rat_done,
    output rename_pkg::phys_reg_t       phys_reg,
    output rename_pkg::phys_reg_t       old_reg,
    output logic                        phys_reg_valid
);

    rename_pkg::phys_reg_t free_idx;
    logic                  free_found;
    logic                  does_rename;
    rename_pkg::arch_reg_t slot;

    // lowest set bit wins, so scan downwards
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = `PHYS_REGS-3; i >= 0; i--) begin
            if (free_pool[i]) begin
                free_idx   = rename_pkg::phys_reg_t'(i);
                free_found = 1'b1;
            end
        end
    end

    assign does_rename = (arch_reg != 4'h0) && (arch_reg != 4'h1);
    assign slot        = arch_reg - 4'd2;

    assign phys_reg = does_rename ? free_idx + 5'd2 : {1'b0, arch_reg};
    assign old_reg  = does_rename ? rat_aliases[slot*`PR_ADDR_W +: `PR_ADDR_W]
                                  : {1'b0, arch_reg};

    assign phys_reg_valid = !does_rename || free_found;

    always_comb begin
        new_free_pool   = free_pool;
        new_rat_aliases = rat_aliases;
        new_rat_done    = rat_done;
        if (does_rename) begin
            new_free_pool[free_idx] = 1'b0;
            new_rat_aliases[slot*`PR_ADDR_W +: `PR_ADDR_W] = phys_reg;
            new_rat_done[slot] = 1'b0; // value not produced yet
        end
    end

endmodule

`default_nettype wire

// File: renamer/renamer.sv
// Two destination renamer
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module renamer (
    input  wire rename_pkg::arch_reg_t  dst_a,
    input  wire rename_pkg::arch_reg_t  dst_b,
    input  wire rename_pkg::arch_reg_t  src_a,
    input  wire rename_pkg::arch_reg_t  src_b,
    input  wire logic                   micro_op_valid,
    input  wire rename_pkg::free_pool_t free_pool,
    input  wire rename_pkg::rat_t       rat_aliases,
    input  wire rename_pkg::done_t      rat_done,
    output rename_pkg::free_pool_t      new_free_pool,
    output rename_pkg::rat_t            new_rat_aliases,
    output rename_pkg::done_t           new_rat_done,
    output rename_pkg::phys_reg_t       phys_a,
    output rename_pkg::phys_reg_t       phys_b,
    output rename_pkg::phys_reg_t       old_a,
    output rename_pkg::phys_reg_t       old_b,
    output rename_pkg::phys_reg_t       src_phys_a,
    output rename_pkg::phys_reg_t       src_phys_b,
    output logic                        src_ready_a,
    output logic                        src_ready_b,
    output logic                        rename_valid
);

    rename_pkg::free_pool_t pool_mid;
    rename_pkg::rat_t       aliases_mid;
    rename_pkg::done_t      done_mid;
    logic                   valid_a;
    logic                   valid_b;
    rename_pkg::arch_reg_t  src_slot_a;
    rename_pkg::arch_reg_t  src_slot_b;

    renamer_cell u_cell_a (
        .arch_reg        (dst_a),
        .free_pool       (free_pool),
        .rat_aliases     (rat_aliases),
        .rat_done        (rat_done),
        .new_free_pool   (pool_mid),
        .new_rat_aliases (aliases_mid),
        .new_rat_done    (done_mid),
        .phys_reg        (phys_a),
        .old_reg         (old_a),
        .phys_reg_valid  (valid_a)
    );

    // b sees a's allocation, so b's alias wins on a clash
    renamer_cell u_cell_b (
        .arch_reg        (dst_b),
        .free_pool       (pool_mid),
        .rat_aliases     (aliases_mid),
        .rat_done        (done_mid),
        .new_free_pool   (new_free_pool),
        .new_rat_aliases (new_rat_aliases),
        .new_rat_done    (new_rat_done),
        .phys_reg        (phys_b),
        .old_reg         (old_b),
        .phys_reg_valid  (valid_b)
    );

    assign rename_valid = micro_op_valid && valid_a && valid_b;

    // sources read the table as it was before this op
    assign src_slot_a  = src_a - 4'd2;
    assign src_slot_b  = src_b - 4'd2;
    assign src_phys_a  = (src_a < 4'd2) ? {1'b0, src_a}
                                        : rat_aliases[src_slot_a*`PR_ADDR_W +: `PR_ADDR_W];
    assign src_phys_b  = (src_b < 4'd2) ? {1'b0, src_b}
                                        : rat_aliases[src_slot_b*`PR_ADDR_W +: `PR_ADDR_W];
    assign src_ready_a = (src_a < 4'd2) || rat_done[src_slot_a]; // fixed regs always done
    assign src_ready_b = (src_b < 4'd2) || rat_done[src_slot_b];

endmodule

`default_nettype wire

// File: renamer/rename_state.sv
// Free pool, alias table and done bits
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rename_state (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   commit,
    input  wire rename_pkg::free_pool_t new_free_pool,
    input  wire rename_pkg::rat_t       new_rat_aliases,
    input  wire rename_pkg::done_t      new_rat_done,
    input  wire logic                   release_valid,
    input  wire rename_pkg::phys_reg_t  release_reg,
    input  wire logic                   wb_valid,
    input  wire rename_pkg::phys_reg_t  wb_reg,
    output rename_pkg::free_pool_t      free_pool,
    output rename_pkg::rat_t            rat_aliases,
    output rename_pkg::done_t           rat_done
);

    // identity mapping for every renamed register
    function automatic rename_pkg::rat_t rat_reset_value();
        rename_pkg::rat_t v = '0;
        for (int r = 2; r < `ARCH_REGS; r++) begin
            v[(r-2)*`PR_ADDR_W +: `PR_ADDR_W] = rename_pkg::phys_reg_t'(r);
        end
        return v;
    endfunction

    // registers at or above ARCH_REGS start free
    localparam rename_pkg::free_pool_t POOL_RESET =
        ~rename_pkg::free_pool_t'(0) << (`ARCH_REGS - 2);
    localparam rename_pkg::rat_t RAT_RESET = rat_reset_value();

    rename_pkg::free_pool_t pool_next;
    rename_pkg::rat_t       aliases_next;
    rename_pkg::done_t      done_next;
    rename_pkg::phys_reg_t  release_slot;

    assign release_slot = release_reg - 5'd2;

    always_comb begin
        pool_next    = commit ? new_free_pool : free_pool;
        aliases_next = commit ? new_rat_aliases : rat_aliases;
        done_next    = commit ? new_rat_done : rat_done;

        if (release_valid) begin
            pool_next[release_slot] = 1'b1; // retired reg back to pool
        end

        // writeback marks every register aliasing wb_reg after rename
        if (wb_valid) begin
            for (int r = 0; r < `RENAMED_REGS; r++) begin
                if (aliases_next[r*`PR_ADDR_W +: `PR_ADDR_W] == wb_reg) begin
                    done_next[r] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_pool   <= POOL_RESET;
            rat_aliases <= RAT_RESET;
            rat_done    <= '1;
        end else begin
            free_pool   <= pool_next;
            rat_aliases <= aliases_next;
            rat_done    <= done_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_unit.sv
// Register rename stage
`timescale 1ns/1ns
`default_nettype none

module rename_unit (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [23:0]           micro_op,
    input  wire logic                  micro_op_valid,
    input  wire logic                  release_valid,
    input  wire rename_pkg::phys_reg_t release_reg,
    input  wire logic                  wb_valid,
    input  wire rename_pkg::phys_reg_t wb_reg,
    output rename_pkg::phys_reg_t      phys_a,
    output rename_pkg::phys_reg_t      phys_b,
    output rename_pkg::phys_reg_t      old_a,
    output rename_pkg::phys_reg_t      old_b,
    output logic                       nop,
    output rename_pkg::phys_reg_t      src_phys_a,
    output rename_pkg::phys_reg_t      src_phys_b,
    output logic                       src_ready_a,
    output logic                       src_ready_b,
    output logic                       rename_valid
);

    rename_pkg::arch_reg_t  dst_a;
    rename_pkg::arch_reg_t  dst_b;
    rename_pkg::free_pool_t free_pool;
    rename_pkg::rat_t       rat_aliases;
    rename_pkg::done_t      rat_done;
    rename_pkg::free_pool_t new_free_pool;
    rename_pkg::rat_t       new_rat_aliases;
    rename_pkg::done_t      new_rat_done;

    dest_decode u_dest_decode (
        .micro_op (micro_op),
        .dst_a    (dst_a),
        .dst_b    (dst_b),
        .nop      (nop)
    );

    renamer u_renamer (
        .dst_a           (dst_a),
        .dst_b           (dst_b),
        .src_a           (micro_op[11:8]),
        .src_b           (micro_op[7:4]),
        .micro_op_valid  (micro_op_valid),
        .free_pool       (free_pool),
        .rat_aliases     (rat_aliases),
        .rat_done        (rat_done),
        .new_free_pool   (new_free_pool),
        .new_rat_aliases (new_rat_aliases),
        .new_rat_done    (new_rat_done),
        .phys_a          (phys_a),
        .phys_b          (phys_b),
        .old_a           (old_a),
        .old_b           (old_b),
        .src_phys_a      (src_phys_a),
        .src_phys_b      (src_phys_b),
        .src_ready_a     (src_ready_a),
        .src_ready_b     (src_ready_b),
        .rename_valid    (rename_valid)
    );

    rename_state u_rename_state (
        .clk             (clk),
        .rst_n           (rst_n),
        .commit          (rename_valid), // stall holds state
        .new_free_pool   (new_free_pool),
        .new_rat_aliases (new_rat_aliases),
        .new_rat_done    (new_rat_done),
        .release_valid   (release_valid),
        .release_reg     (release_reg),
        .wb_valid        (wb_valid),
        .wb_reg          (wb_reg),
        .free_pool       (free_pool),
        .rat_aliases     (rat_aliases),
        .rat_done        (rat_done)
    );

endmodule

`default_nettype wire

// File: testbench/rename_unit_props.sv
// Rename state assertions
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rename_unit_props (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire logic                   commit,
    input wire logic                   micro_op_valid,
    input wire rename_pkg::free_pool_t free_pool,
    input wire rename_pkg::rat_t       new_rat_aliases,
    input wire logic                   release_valid,
    input wire rename_pkg::phys_reg_t  release_reg
);

    int unsigned fail_count = 0; // failed assertion attempts

    // two slots holding one physical register
    function automatic logic has_clash(rename_pkg::rat_t a);
        for (int i = 0; i < `RENAMED_REGS; i++) begin
            for (int j = i + 1; j < `RENAMED_REGS; j++) begin
                if (a[i*`PR_ADDR_W +: `PR_ADDR_W] == a[j*`PR_ADDR_W +: `PR_ADDR_W]) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    function automatic logic has_fixed(rename_pkg::rat_t a);
        for (int i = 0; i < `RENAMED_REGS; i++) begin
            if (a[i*`PR_ADDR_W +: `PR_ADDR_W] < 5'd2) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    a_commit_needs_op: assert property (@(posedge clk) disable iff (!rst_n)
        commit |-> micro_op_valid)
        else begin
            $error("state committed without a valid micro-op");
            fail_count++;
        end

    a_alloc_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        commit |-> !has_clash(new_rat_aliases))
        else begin
            $error("one physical register allocated twice");
            fail_count++;
        end

    a_alloc_range: assert property (@(posedge clk) disable iff (!rst_n)
        commit |-> !has_fixed(new_rat_aliases))
        else begin
            $error("fixed physical register allocated");
            fail_count++;
        end

    a_release_not_free: assert property (@(posedge clk) disable iff (!rst_n)
        release_valid |-> !free_pool[release_reg - 5'd2])
        else begin
            $error("released register was already free");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: testbench/rename_unit_tb.sv
// Rename stage testbench
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rename_unit_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int N_CYCLES        = 2000;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_CYCLES + 7;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [23:0] micro_op;
    logic        micro_op_valid;
    logic        release_valid;
    logic [4:0]  release_reg;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [4:0]  phys_a;
    logic [4:0]  phys_b;
    logic [4:0]  old_a;
    logic [4:0]  old_b;
    logic        nop;
    logic [4:0]  src_phys_a;
    logic [4:0]  src_phys_b;
    logic        src_ready_a;
    logic        src_ready_b;
    logic        rename_valid;

    // reference model state, indexed by real register ids
    bit pool_m [2:31];
    int rat_m [2:11];
    bit done_m [2:11];
    bit nxt_pool [2:31];
    int nxt_rat [2:11];
    bit nxt_done [2:11];
    int retired_q [$]; // unmapped and not yet free

    always #(CLK_PERIOD / 2) clk = ~clk;

    rename_unit u_rename_unit (.*);

    bind rename_state rename_unit_props u_rename_unit_props (
        .clk             (clk),
        .rst_n           (rst_n),
        .commit          (commit),
        .micro_op_valid  (rename_unit_tb.u_rename_unit.micro_op_valid),
        .free_pool       (free_pool),
        .new_rat_aliases (new_rat_aliases),
        .release_valid   (release_valid),
        .release_reg     (release_reg)
    );

    task automatic expect_value(input string name, input int exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %s expected %h got %h", name, exp, got);
            $display("Done: errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic poll_assertions();
        assert (u_rename_unit.u_rename_state.u_rename_unit_props.fail_count == 0) else begin
            $display("a concurrent assertion on the rename state failed");
            $display("Done: errors found");
            $fatal(1, "property violation");
        end
    endtask

    task automatic decode_dests(input logic [23:0] op, output int da, output int db);
        case (op[23:20])
            4'b1100: begin
                da = 0;
                db = op[15:12];
            end
            4'b1101: begin
                da = 0;
                db = 0;
            end
            4'b1110, 4'b1111: begin
                da = 11; // pc halves
                db = 10;
            end
            default: begin
                da = op[19:16];
                db = op[15:12];
            end
        endcase
    endtask

    // works on the nxt_ copies so B sees A's allocation
    task automatic rename_dest(input int a, output int phys, output int old, output bit ok);
        phys = a;
        old  = a;
        ok   = 1'b1;
        if (a >= 2) begin
            ok = 1'b0;
            for (int i = 31; i >= 2; i--) begin
                if (nxt_pool[i]) begin
                    phys = i;
                    ok   = 1'b1;
                end
            end
            if (ok) begin
                old           = nxt_rat[a];
                nxt_pool[phys] = 1'b0;
                nxt_rat[a]    = phys;
                nxt_done[a]   = 1'b0;
            end
        end
    endtask

    task automatic verify_source(input int s, input logic [4:0] phys, input logic ready,
                                 input string tag);
        expect_value({"src_phys_", tag}, (s < 2) ? s : rat_m[s], phys);
        expect_value({"src_ready_", tag}, (s < 2) ? 1 : done_m[s], ready);
    endtask

    initial begin
        int unsigned seed;
        int          da, db, pa, pb, oa, ob, r, rel_pct;
        bit          ok_a, ok_b, exp_valid, hold;
        seed           = $urandom(32'h2acc);
        rst_n          = 1'b0;
        micro_op       = '0;
        micro_op_valid = 1'b0;
        release_valid  = 1'b0;
        release_reg    = '0;
        wb_valid       = 1'b0;
        wb_reg         = '0;
        hold           = 1'b0;
        for (int i = 2; i < `PHYS_REGS; i++) begin
            pool_m[i] = (i >= `ARCH_REGS);
        end
        for (int i = 2; i < `ARCH_REGS; i++) begin
            rat_m[i]  = i;
            done_m[i] = 1'b1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int k = 0; k < N_CYCLES; k++) begin
            if (!hold) begin
                micro_op[23:20] = 4'($urandom_range(15, 0));
                micro_op[19:16] = 4'($urandom_range(11, 0));
                micro_op[15:12] = 4'($urandom_range(11, 0));
                micro_op[11:8]  = 4'($urandom_range(11, 0));
                micro_op[7:4]   = 4'($urandom_range(11, 0));
                micro_op[3:0]   = 4'($urandom);
                if ($urandom_range(7, 0) == 0) begin
                    micro_op[15:12] = micro_op[19:16]; // same dest twice
                end
                if ($urandom_range(15, 0) == 0) begin
                    micro_op[23:12] = 12'h0;
                end
                micro_op_valid = ($urandom_range(9, 0) < 8);
            end
            // slow release phases drain the pool, fast ones refill it
            rel_pct       = ((k / 250) % 2 == 1) ? 75 : 10;
            release_valid = 1'b0;
            if (retired_q.size() > 0 && $urandom_range(99, 0) < rel_pct) begin
                r             = $urandom_range(retired_q.size() - 1, 0);
                release_reg   = 5'(retired_q[r]);
                release_valid = 1'b1;
                retired_q.delete(r);
            end
            wb_valid = ($urandom_range(1, 0) == 1);
            wb_reg   = 5'(rat_m[$urandom_range(11, 2)]);

            @(negedge clk);
            decode_dests(micro_op, da, db);
            nxt_pool = pool_m;
            nxt_rat  = rat_m;
            nxt_done = done_m;
            rename_dest(da, pa, oa, ok_a);
            rename_dest(db, pb, ob, ok_b);
            exp_valid = micro_op_valid && ok_a && ok_b;
            expect_value("rename_valid", exp_valid, rename_valid);
            expect_value("nop", (micro_op[23:20] == 0) && (da == 0) && (db == 0), nop);
            verify_source(micro_op[11:8], src_phys_a, src_ready_a, "a");
            verify_source(micro_op[7:4], src_phys_b, src_ready_b, "b");
            if (exp_valid) begin
                expect_value("phys_a", pa, phys_a);
                expect_value("old_a", oa, old_a);
                expect_value("phys_b", pb, phys_b);
                expect_value("old_b", ob, old_b);
                pool_m = nxt_pool;
                rat_m  = nxt_rat;
                done_m = nxt_done;
                if (da >= 2) retired_q.push_back(oa);
                if (db >= 2) retired_q.push_back(ob);
            end
            if (release_valid) pool_m[release_reg] = 1'b1;
            if (wb_valid) begin
                for (int i = 2; i < `ARCH_REGS; i++) begin
                    if (rat_m[i] == wb_reg) done_m[i] = 1'b1;
                end
            end
            hold = micro_op_valid && !exp_valid; // stalled op stays offered
            @(posedge clk);
            #1;
            poll_assertions();
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/rename_pkg.sv
logic/dest_decode.sv
renamer/renamer_cell.sv
renamer/renamer.sv
renamer/rename_state.sv
logic/rename_unit.sv
testbench/rename_unit_props.sv
testbench/rename_unit_tb.sv
